/* hw/bus_pkg.sv */
package bus_pkg;

    localparam int data_width   = 16;
    localparam int addr_width   = 12;   // log2 of the deepest slave
    localparam int master_count = 2;
    localparam int slave_count  = 3;

    localparam int slave_depths [slave_count] = '{4096, 4096, 2048};

    // control frame is slave id, write bit, address, msb first
    localparam int frame_len = 15;
    localparam int tx_width  = frame_len + data_width;   // frame plus write word
    localparam int cnt_width = $clog2(data_width);       // also covers frame_len

    typedef logic [1:0] slave_id_t;    // 0 means no slave
    typedef logic       master_id_t;

    typedef enum logic [2:0] {
        m_idle,
        m_request,
        m_send_ctrl,
        m_send_data,
        m_recv_data,
        m_finish
    } master_state_t;

    typedef enum logic [1:0] {
        s_listen,
        s_take_data,
        s_write_mem,
        s_send_data
    } slave_state_t;

    typedef enum logic {
        arb_free,
        arb_owned
    } arb_state_t;

endpackage : bus_pkg

/* hw/serial_bus_if.sv */
`timescale 1ns/100ps

interface serial_bus_if;

    logic control;   // frame bits, msb first
    logic wdata;
    logic valid;
    logic last;
    logic rdata;
    logic ready;     // write ack pulse, or read data strobe

    modport master (
        output control, wdata, valid, last,
        input  rdata, ready
    );

    modport slave (
        input  control, wdata, valid, last,
        output rdata, ready
    );

endinterface : serial_bus_if

/* hw/bus_master.sv */
`timescale 1ns/100ps

module bus_master (
    input  logic                           clk,
    input  logic                           rstN,
    input  logic                           start,
    input  logic                           write,
    input  bus_pkg::slave_id_t             slave_id,
    input  logic [bus_pkg::addr_width-1:0] addr,
    input  logic [bus_pkg::data_width-1:0] wdata,
    output logic                           done,
    output logic [bus_pkg::data_width-1:0] rdata,
    output logic                           req,
    output bus_pkg::slave_id_t             req_slave,
    input  logic                           grant,
    serial_bus_if.master                   bus
);

    import bus_pkg::*;

    master_state_t          state;
    logic [cnt_width-1:0]   cnt;
    logic                   cmd_write;
    logic [tx_width-1:0]    tx;       // frame then write word
    logic [data_width-1:0]  rx;

    logic frame_end;
    logic data_end;

    assign frame_end = (cnt == cnt_width'(frame_len - 1));
    assign data_end  = (cnt == cnt_width'(data_width - 1));

    // serial outputs come straight off the shifter msb
    assign bus.valid   = (state == m_send_ctrl) || (state == m_send_data);
    assign bus.control = (state == m_send_ctrl) && tx[tx_width-1];
    assign bus.wdata   = (state == m_send_data) && tx[tx_width-1];
    assign bus.last    = ((state == m_send_ctrl) && !cmd_write && frame_end) ||
                         ((state == m_send_data) && data_end);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= m_idle;
            cnt       <= '0;
            cmd_write <= 1'b0;
            req       <= 1'b0;
            req_slave <= '0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                m_idle: begin
                    if (start) begin
                        cmd_write <= write;
                        cnt       <= '0;
                        if (slave_id == '0) begin
                            state <= m_finish;   // no slave, skip the bus
                        end else begin
                            req       <= 1'b1;
                            req_slave <= slave_id;
                            state     <= m_request;
                        end
                    end
                end
                m_request: begin
                    if (grant) state <= m_send_ctrl;
                end
                m_send_ctrl: begin
                    cnt <= cnt + 1'b1;
                    if (frame_end) begin
                        cnt   <= '0;
                        state <= cmd_write ? m_send_data : m_recv_data;
                    end
                end
                m_send_data: begin
                    cnt <= cnt + 1'b1;
                    if (data_end) begin
                        cnt   <= '0;
                        state <= m_recv_data;
                    end
                end
                m_recv_data: begin
                    // write waits for the ack and read counts data bits
                    if (bus.ready) begin
                        cnt <= cnt + 1'b1;
                        if (cmd_write || data_end) state <= m_finish;
                    end
                end
                m_finish: begin
                    done      <= 1'b1;
                    req       <= 1'b0;
                    req_slave <= '0;
                    state     <= m_idle;
                end
                default: state <= m_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == m_idle && start) begin
            tx <= {slave_id, write, addr, wdata};
            rx <= '0;
        end else if (state == m_send_ctrl || state == m_send_data) begin
            tx <= tx << 1;
        end else if (state == m_recv_data && bus.ready && !cmd_write) begin
            rx <= {rx[data_width-2:0], bus.rdata};
        end
        if (state == m_finish) rdata <= rx;   // held until the next done
    end

endmodule : bus_master

/* hw/bus_slave.sv */
`timescale 1ns/100ps

module bus_slave #(
    parameter int depth = 4096
) (
    input  logic        clk,
    input  logic        rstN,
    serial_bus_if.slave bus
);

    import bus_pkg::*;

    localparam int addr_bits = $clog2(depth);

    slave_state_t           state;
    logic [cnt_width-1:0]   cnt;

    logic [data_width-1:0]  mem [depth];
    logic [addr_bits-1:0]   addr_q;     // only the low bits survive the shift
    logic                   wr_q;
    logic [data_width-1:0]  data_q;
    logic [data_width-1:0]  rd_shift;

    logic [addr_bits-1:0]   addr_next;
    logic                   frame_end;

    assign addr_next = {addr_q[addr_bits-2:0], bus.control};
    assign frame_end = bus.valid && (cnt == cnt_width'(frame_len - 1));

    assign bus.ready = (state == s_write_mem) || (state == s_send_data);
    assign bus.rdata = (state == s_send_data) && rd_shift[data_width-1];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= s_listen;
            cnt   <= '0;
        end else begin
            case (state)
                s_listen: begin
                    if (bus.valid) begin
                        cnt <= cnt + 1'b1;
                        if (frame_end) begin
                            cnt   <= '0;
                            state <= wr_q ? s_take_data : s_send_data;
                        end
                    end
                end
                s_take_data: begin
                    if (bus.valid && bus.last) state <= s_write_mem;
                end
                s_write_mem: state <= s_listen;   // single ready pulse
                s_send_data: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == cnt_width'(data_width - 1)) begin
                        cnt   <= '0;
                        state <= s_listen;
                    end
                end
                default: state <= s_listen;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            s_listen: begin
                if (bus.valid) begin
                    addr_q <= addr_next;
                    // the write bit follows the two id bits
                    if (cnt == cnt_width'($bits(slave_id_t))) wr_q <= bus.control;
                    if (frame_end && !wr_q) rd_shift <= mem[addr_next];
                end
            end
            s_take_data: begin
                if (bus.valid) data_q <= {data_q[data_width-2:0], bus.wdata};
            end
            s_write_mem: mem[addr_q] <= data_q;
            s_send_data: rd_shift <= rd_shift << 1;
            default: ;
        endcase
    end

endmodule : bus_slave

/* hw/bus_arbiter.sv */
`timescale 1ns/100ps

module bus_arbiter (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic [bus_pkg::master_count-1:0] req,
    input  bus_pkg::slave_id_t               req_slave [bus_pkg::master_count],
    output logic [bus_pkg::master_count-1:0] grant,
    output bus_pkg::master_id_t              grant_master,
    output bus_pkg::slave_id_t               grant_slave,
    output logic                             bus_busy
);

    import bus_pkg::*;

    arb_state_t state;
    master_id_t last_granted;
    master_id_t pick;
    logic       found;

    assign bus_busy = (state == arb_owned);

    // search starts just after the last winner, so it loses ties
    always_comb begin
        pick  = last_granted;
        found = 1'b0;
        for (int i = 1; i <= master_count; i++) begin
            if (!found && req[master_id_t'(last_granted + i)]) begin
                pick  = master_id_t'(last_granted + i);
                found = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state        <= arb_free;
            grant        <= '0;
            grant_master <= '0;
            grant_slave  <= '0;
            last_granted <= master_id_t'(master_count - 1);   // master 0 wins first tie
        end else begin
            case (state)
                arb_free: begin
                    if (found) begin
                        grant        <= '0;
                        grant[pick]  <= 1'b1;
                        grant_master <= pick;
                        grant_slave  <= req_slave[pick];
                        state        <= arb_owned;
                    end
                end
                arb_owned: begin
                    if (!req[grant_master]) begin
                        grant        <= '0;
                        grant_slave  <= '0;
                        last_granted <= grant_master;
                        state        <= arb_free;
                    end
                end
                default: state <= arb_free;
            endcase
        end
    end

endmodule : bus_arbiter

/* hw/bus_interconnect.sv */
`timescale 1ns/100ps

module bus_interconnect (
    input  logic                bus_busy,
    input  bus_pkg::master_id_t grant_master,
    input  bus_pkg::slave_id_t  grant_slave,
    serial_bus_if.slave         m_bus [bus_pkg::master_count],
    serial_bus_if.master        s_bus [bus_pkg::slave_count]
);

    import bus_pkg::*;

    logic [master_count-1:0] m_control, m_wdata, m_valid, m_last;
    logic [slave_count-1:0]  s_rdata, s_ready;

    logic sel_control, sel_wdata, sel_valid, sel_last;
    logic sel_rdata, sel_ready;

    // collect forward lines from the masters and return the selected slave
    for (genvar gm = 0; gm < master_count; gm++) begin : g_master
        logic hit;
        assign hit = bus_busy && (grant_master == master_id_t'(gm));

        assign m_control[gm] = m_bus[gm].control;
        assign m_wdata[gm]   = m_bus[gm].wdata;
        assign m_valid[gm]   = m_bus[gm].valid;
        assign m_last[gm]    = m_bus[gm].last;

        assign m_bus[gm].rdata = hit && sel_rdata;
        assign m_bus[gm].ready = hit && sel_ready;
    end

    always_comb begin
        sel_control = m_control[grant_master];
        sel_wdata   = m_wdata[grant_master];
        sel_valid   = m_valid[grant_master];
        sel_last    = m_last[grant_master];
        sel_rdata   = 1'b0;
        sel_ready   = 1'b0;
        for (int i = 0; i < slave_count; i++) begin
            if (grant_slave == slave_id_t'(i + 1)) begin   // id 0 picks nothing
                sel_rdata = s_rdata[i];
                sel_ready = s_ready[i];
            end
        end
    end

    // only the addressed slave sees any activity
    for (genvar gs = 0; gs < slave_count; gs++) begin : g_slave
        logic hit;
        assign hit = bus_busy && (grant_slave == slave_id_t'(gs + 1));

        assign s_bus[gs].control = hit && sel_control;
        assign s_bus[gs].wdata   = hit && sel_wdata;
        assign s_bus[gs].valid   = hit && sel_valid;
        assign s_bus[gs].last    = hit && sel_last;

        assign s_rdata[gs] = s_bus[gs].rdata;
        assign s_ready[gs] = s_bus[gs].ready;
    end

endmodule : bus_interconnect

/* hw/bus_system.sv */
`timescale 1ns/100ps

module bus_system (
    input  logic                           clk,
    input  logic                           rstN,

    input  logic                           m0_start,
    input  logic                           m0_write,
    input  bus_pkg::slave_id_t             m0_slave_id,
    input  logic [bus_pkg::addr_width-1:0] m0_addr,
    input  logic [bus_pkg::data_width-1:0] m0_wdata,
    output logic                           m0_done,
    output logic [bus_pkg::data_width-1:0] m0_rdata,

    input  logic                           m1_start,
    input  logic                           m1_write,
    input  bus_pkg::slave_id_t             m1_slave_id,
    input  logic [bus_pkg::addr_width-1:0] m1_addr,
    input  logic [bus_pkg::data_width-1:0] m1_wdata,
    output logic                           m1_done,
    output logic [bus_pkg::data_width-1:0] m1_rdata
);

    import bus_pkg::*;

    logic [master_count-1:0] req;
    logic [master_count-1:0] grant;
    slave_id_t               req_slave [master_count];
    master_id_t              grant_master;
    slave_id_t               grant_slave;
    logic                    bus_busy;

    serial_bus_if m_if [master_count] ();   // master side of the interconnect
    serial_bus_if s_if [slave_count] ();    // slave side

    bus_master u_master0 (
        .clk       (clk),
        .rstN      (rstN),
        .start     (m0_start),
        .write     (m0_write),
        .slave_id  (m0_slave_id),
        .addr      (m0_addr),
        .wdata     (m0_wdata),
        .done      (m0_done),
        .rdata     (m0_rdata),
        .req       (req[0]),
        .req_slave (req_slave[0]),
        .grant     (grant[0]),
        .bus       (m_if[0])
    );

    bus_master u_master1 (
        .clk       (clk),
        .rstN      (rstN),
        .start     (m1_start),
        .write     (m1_write),
        .slave_id  (m1_slave_id),
        .addr      (m1_addr),
        .wdata     (m1_wdata),
        .done      (m1_done),
        .rdata     (m1_rdata),
        .req       (req[1]),
        .req_slave (req_slave[1]),
        .grant     (grant[1]),
        .bus       (m_if[1])
    );

    for (genvar gs = 0; gs < slave_count; gs++) begin : g_slave
        bus_slave #(
            .depth (slave_depths[gs])
        ) u_slave (
            .clk  (clk),
            .rstN (rstN),
            .bus  (s_if[gs])
        );
    end

    bus_arbiter u_arbiter (
        .clk          (clk),
        .rstN         (rstN),
        .req          (req),
        .req_slave    (req_slave),
        .grant        (grant),
        .grant_master (grant_master),
        .grant_slave  (grant_slave),
        .bus_busy     (bus_busy)
    );

    bus_interconnect u_interconnect (
        .bus_busy     (bus_busy),
        .grant_master (grant_master),
        .grant_slave  (grant_slave),
        .m_bus        (m_if),
        .s_bus        (s_if)
    );

endmodule : bus_system

/* verification/bus_checker.sv */
`timescale 1ns/100ps

module bus_checker (
    input  logic                                clk,
    input  logic                                rstN,
    input  logic [1:0]                          start,
    input  logic [1:0]                          write,
    input  logic [1:0][1:0]                     slave_id,
    input  logic [1:0][bus_pkg::addr_width-1:0] addr,
    input  logic [1:0][bus_pkg::data_width-1:0] wdata,
    input  logic [1:0]                          done,
    input  logic [1:0][bus_pkg::data_width-1:0] rdata,
    input  logic [1:0][bus_pkg::data_width-1:0] exp_rdata,   // from the stimulus table
    input  logic                                tie,
    input  logic                                first,       // master expected to finish first
    input  logic                                row_end,
    input  logic                                row_timeout,
    output int                                  errors,
    output int                                  rows_failed,
    output int                                  rows_run
);

    import bus_pkg::*;

    logic [data_width-1:0]      shadow [int];   // one word per slave and aliased address
    logic [1:0]                 busy;
    logic [1:0][1:0]            c_sid;
    logic [1:0]                 c_wr;
    logic [1:0][addr_width-1:0] c_addr;
    logic [1:0][data_width-1:0] c_wd;
    int                         cyc [2];
    int                         row_errors;
    logic                       order_seen;

    initial begin
        errors      = 0;
        rows_failed = 0;
        rows_run    = 0;
        row_errors  = 0;
        order_seen  = 1'b0;
        busy        = '0;
    end

    // short slaves only decode the low address bits
    function automatic int key_of(logic [1:0] sid, logic [addr_width-1:0] a);
        return int'(sid) * (1 << addr_width) + int'(a) % slave_depths[int'(sid) - 1];
    endfunction

    task automatic report_mismatch(input string name, input logic [data_width-1:0] exp_val,
                                   input logic [data_width-1:0] act_val);
        $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp_val, act_val);
        errors++;
        row_errors++;
    endtask

    task automatic report_failure(input string what);
        $display("Error at %0t: %s", $time, what);
        errors++;
        row_errors++;
    endtask

    task automatic check_done(input int i);
        logic [data_width-1:0] ref_word;
        logic                  check_rd;
        int                    key;
        ref_word = '0;   // no-slave commands return zero
        check_rd = 1'b1;
        key      = 0;
        if (tie && !order_seen) begin
            order_seen = 1'b1;
            if (i != int'(first)) report_mismatch("first_done_master", 16'(first), 16'(i));
        end
        if (c_sid[i] == 2'd0) begin
            if (cyc[i] != 2) report_mismatch($sformatf("m%0d_done_latency", i), 16'd2, 16'(cyc[i]));
        end else begin
            key = key_of(c_sid[i], c_addr[i]);
            if (c_wr[i]) begin
                shadow[key] = c_wd[i];
                check_rd    = 1'b0;
            end else if (shadow.exists(key)) begin
                ref_word = shadow[key];
            end else begin
                report_failure($sformatf("master %0d read a location never written", i));
            end
        end
        if (check_rd && rdata[i] !== ref_word)
            report_mismatch($sformatf("m%0d_rdata", i), ref_word, rdata[i]);
        if (check_rd && rdata[i] !== exp_rdata[i])
            report_mismatch($sformatf("m%0d_rdata (table)", i), exp_rdata[i], rdata[i]);
    endtask

    always @(posedge clk) begin
        if (!rstN) begin
            busy = '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (busy[i]) cyc[i]++;
                if (done[i]) begin
                    if (busy[i]) check_done(i);
                    else report_failure($sformatf("master %0d gave done with nothing pending", i));
                    busy[i] = 1'b0;
                end else if (start[i] && !busy[i]) begin   // a start while busy is dropped
                    busy[i]   = 1'b1;
                    cyc[i]    = 0;
                    c_sid[i]  = slave_id[i];
                    c_wr[i]   = write[i];
                    c_addr[i] = addr[i];
                    c_wd[i]   = wdata[i];
                end
            end
            if (row_end) begin
                rows_run++;
                if (row_timeout) report_failure("timed out waiting for done");
                if (row_errors == 0) begin
                    $display("test %0d: passed", rows_run);
                end else begin
                    rows_failed++;
                    $display("test %0d: failed with %0d errors", rows_run, row_errors);
                end
                row_errors = 0;
                order_seen = 1'b0;
            end
        end
    end

endmodule : bus_checker

/* verification/bus_system_tb.sv */
`timescale 1ns/100ps

module bus_system_tb;

    import bus_pkg::*;

    typedef struct packed {
        logic                  start;
        logic                  write;
        slave_id_t             sid;
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] wdata;
        logic [data_width-1:0] expect_rd;   // read word expected at done
    } cmd_t;

    typedef struct packed {
        cmd_t [1:0] c;
        logic       poke;    // restart master 0 while it is busy
        logic       tie;
        logic       first;   // master that should finish first in a tie
    } row_t;

    localparam int timeout_cycles = 300;

    logic                  clk;
    logic                  rstN;
    logic                  m0_start, m0_write, m0_done;
    logic                  m1_start, m1_write, m1_done;
    slave_id_t             m0_slave_id, m1_slave_id;
    logic [addr_width-1:0] m0_addr, m1_addr;
    logic [data_width-1:0] m0_wdata, m1_wdata, m0_rdata, m1_rdata;

    row_t                  rows [$];
    row_t                  cur;
    logic                  row_end;
    logic                  timed_out;
    logic                  last_granted;   // tie model of the arbiter
    logic [data_width-1:0] d [10];
    logic [data_width-1:0] later;
    logic [1:0]            pending;
    int                    cyc;
    int                    errors, rows_failed, rows_run;

    function automatic cmd_t write_cmd(slave_id_t sid, logic [addr_width-1:0] a,
                                       logic [data_width-1:0] wd);
        return {1'b1, 1'b1, sid, a, wd, 16'h0};
    endfunction

    function automatic cmd_t read_cmd(slave_id_t sid, logic [addr_width-1:0] a,
                                      logic [data_width-1:0] e);
        return {1'b1, 1'b0, sid, a, 16'h0, e};
    endfunction

    function automatic cmd_t no_cmd();
        return '0;
    endfunction

    task automatic add_row(input cmd_t c0, input cmd_t c1, input logic poke);
        row_t r;
        logic req0;
        logic req1;
        req0   = c0.start && c0.sid != 2'd0;   // id 0 never requests
        req1   = c1.start && c1.sid != 2'd0;
        r.c[0] = c0;
        r.c[1] = c1;
        r.poke = poke;
        r.tie  = req0 && req1;
        r.first = !last_granted;
        // after a tie the loser goes last, so the record keeps its value
        if (req0 && !req1) last_granted = 1'b0;
        if (req1 && !req0) last_granted = 1'b1;
        rows.push_back(r);
    endtask

    bus_system u_bus_system (.*);

    bus_checker u_checker (
        .clk         (clk),
        .rstN        (rstN),
        .start       ({m1_start, m0_start}),
        .write       ({m1_write, m0_write}),
        .slave_id    ({m1_slave_id, m0_slave_id}),
        .addr        ({m1_addr, m0_addr}),
        .wdata       ({m1_wdata, m0_wdata}),
        .done        ({m1_done, m0_done}),
        .rdata       ({m1_rdata, m0_rdata}),
        .exp_rdata   ({cur.c[1].expect_rd, cur.c[0].expect_rd}),
        .tie         (cur.tie),
        .first       (cur.first),
        .row_end     (row_end),
        .row_timeout (timed_out),
        .errors      (errors),
        .rows_failed (rows_failed),
        .rows_run    (rows_run)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    initial begin
        rstN         = 1'b0;
        {m0_start, m0_write, m0_slave_id, m0_addr, m0_wdata} = '0;
        {m1_start, m1_write, m1_slave_id, m1_addr, m1_wdata} = '0;
        cur          = '0;
        row_end      = 1'b0;
        timed_out    = 1'b0;
        last_granted = 1'b1;   // reset lets master 0 win the first tie
        d[0] = 16'($urandom(82));
        for (int k = 1; k < 10; k++) d[k] = 16'($urandom);
        d[8] = ~d[7];   // same-address race needs two different words

        add_row(write_cmd(2'd1, 12'h010, d[0]), write_cmd(2'd2, 12'h020, d[1]), 1'b0);
        add_row(read_cmd(2'd1, 12'h010, d[0]), no_cmd(), 1'b0);
        add_row(read_cmd(2'd2, 12'h020, d[1]), read_cmd(2'd1, 12'h010, d[0]), 1'b0);
        add_row(write_cmd(2'd3, 12'h7ff, d[2]), write_cmd(2'd2, 12'h123, d[3]), 1'b0);
        add_row(read_cmd(2'd3, 12'h7ff, d[2]), read_cmd(2'd2, 12'h123, d[3]), 1'b0);
        // 2048 + 5 lands on 5 in slave 3 only
        add_row(write_cmd(2'd1, 12'h805, d[4]), write_cmd(2'd3, 12'h805, d[5]), 1'b0);
        add_row(write_cmd(2'd1, 12'h005, d[6]), read_cmd(2'd3, 12'h005, d[5]), 1'b0);
        add_row(read_cmd(2'd1, 12'h805, d[4]), read_cmd(2'd1, 12'h005, d[6]), 1'b0);
        add_row(write_cmd(2'd2, 12'h300, d[7]), write_cmd(2'd2, 12'h300, d[8]), 1'b0);
        later = rows[rows.size() - 1].first ? d[7] : d[8];   // second grant writes last
        add_row(read_cmd(2'd2, 12'h300, later), write_cmd(2'd0, 12'h010, ~d[0]), 1'b0);
        add_row(write_cmd(2'd2, 12'h055, d[9]), read_cmd(2'd1, 12'h010, d[0]), 1'b1);
        add_row(read_cmd(2'd2, 12'h055, d[9]), read_cmd(2'd0, 12'h055, 16'h0), 1'b0);

        repeat (2) @(posedge clk);
        rstN <= 1'b1;

        for (int i = 0; i < rows.size() && !timed_out; i++) begin
            @(posedge clk);
            cur         <= rows[i];
            m0_start    <= rows[i].c[0].start;
            m0_write    <= rows[i].c[0].write;
            m0_slave_id <= rows[i].c[0].sid;
            m0_addr     <= rows[i].c[0].addr;
            m0_wdata    <= rows[i].c[0].wdata;
            m1_start    <= rows[i].c[1].start;
            m1_write    <= rows[i].c[1].write;
            m1_slave_id <= rows[i].c[1].sid;
            m1_addr     <= rows[i].c[1].addr;
            m1_wdata    <= rows[i].c[1].wdata;
            @(posedge clk);
            m0_start <= 1'b0;
            m1_start <= 1'b0;
            pending = {rows[i].c[1].start, rows[i].c[0].start};
            cyc     = 0;
            while (pending != 2'b00 && cyc < timeout_cycles) begin
                @(posedge clk);
                cyc++;
                if (m0_done) pending[0] = 1'b0;
                if (m1_done) pending[1] = 1'b0;
                m0_start <= rows[i].poke && cyc == 3;
                if (rows[i].poke && cyc == 3) m0_wdata <= ~m0_wdata;
            end
            if (pending != 2'b00) timed_out = 1'b1;
            row_end <= 1'b1;
            @(posedge clk);
            row_end <= 1'b0;
        end

        repeat (2) @(posedge clk);   // let the checker close the last row
        $display("%0d tests run, %0d failed, %0d errors", rows_run, rows_failed, errors);
        if (timed_out || errors != 0) begin
            $display("Test failures found");
        end else begin
            $display("All tests passed!");
        end
        $finish;
    end

endmodule : bus_system_tb

/* list.f */
hw/bus_pkg.sv
hw/serial_bus_if.sv
hw/bus_master.sv
hw/bus_slave.sv
hw/bus_arbiter.sv
hw/bus_interconnect.sv
hw/bus_system.sv
verification/bus_checker.sv
verification/bus_system_tb.sv
